// File: Makefile
# Verilator flow for the streamed-audio player testbench

TOP := tb_msu_audio

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: fifo_write_if.sv
/*
 * Write side of the sample FIFO.
 * The sector fetcher pushes words through fetch_mp and the FIFO
 * reports its fill level back through fifo_mp.
 */

`timescale 1ns/100ps
`default_nettype none

interface fifo_write_if #(
	parameter int DEPTH_BITS = 12
);
	import msu_pkg::*;

	// One word stored per edge while high
	logic wr_en;
	word_t wr_data;

	// Fill status, updated one edge after a write
	logic [DEPTH_BITS:0] used;
	logic full;

	modport fetch_mp (output wr_en, output wr_data, input used, input full);
	modport fifo_mp (input wr_en, input wr_data, output used, output full);

endinterface

`default_nettype wire

// File: msu_audio_out.sv
/*
 * Sample output stage.
 * Paces FIFO reads with a reload divider, pairs left and right words,
 * scales them by volume and averages the result with the main audio.
 */

`timescale 1ns/100ps
`default_nettype none

module msu_audio_out #(
	parameter int SAMPLE_PERIOD = 566
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic play_trig,
	input  logic playing,
	input  msu_pkg::volume_t volume,
	output logic rd_en,
	input  msu_pkg::word_t rd_data,
	input  logic empty,
	input  msu_pkg::sample_t main_l,
	input  msu_pkg::sample_t main_r,
	output msu_pkg::sample_t audio_l,
	output msu_pkg::sample_t audio_r
);
	import msu_pkg::*;

	localparam int DIV_BITS = $clog2(SAMPLE_PERIOD + 1);
	localparam logic [DIV_BITS-1:0] DIV_RELOAD = DIV_BITS'(SAMPLE_PERIOD);

	logic [DIV_BITS-1:0] div_cnt;
	logic left_chan;
	logic tick;
	word_t hold_l;
	sample_t samp_l;
	sample_t samp_r;
	logic signed [8:0] vol_s;
	logic signed [23:0] prod_l;
	logic signed [23:0] prod_r;
	sample_t msu_l;
	sample_t msu_r;
	logic signed [16:0] mix_l;
	logic signed [16:0] mix_r;

	// ====================
	// Read pacing
	// ====================
	assign tick = (div_cnt == '0);
	// No read on an empty FIFO, the last pair stays on the output
	assign rd_en = tick && playing && !empty && !play_trig;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt <= DIV_RELOAD;
			left_chan <= 1'b1;
		end else if (play_trig) begin
			// Track restarts, so the first data word is a left sample
			div_cnt <= DIV_RELOAD;
			left_chan <= 1'b1;
		end else if (tick) begin
			div_cnt <= DIV_RELOAD;
			if (rd_en)
				left_chan <= !left_chan;
		end else begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	// Left word waits for its right partner so both outputs move together
	always_ff @(posedge clk_sys) begin
		if (rd_en) begin
			if (left_chan) begin
				hold_l <= rd_data;
			end else begin
				samp_l <= sample_t'(hold_l);
				samp_r <= sample_t'(rd_data);
			end
		end
	end

	// ====================
	// Volume and mix
	// ====================
	// Zero-extended volume keeps the product sign from the sample
	assign vol_s = {1'b0, volume};
	assign prod_l = samp_l * vol_s;
	assign prod_r = samp_r * vol_s;

	// Silent share while stopped
	assign msu_l = playing ? prod_l[23:8] : '0;
	assign msu_r = playing ? prod_r[23:8] : '0;

	// 17-bit sum, halved back to 16 bits
	assign mix_l = {main_l[15], main_l} + {msu_l[15], msu_l};
	assign mix_r = {main_r[15], main_r} + {msu_r[15], msu_r};
	assign audio_l = mix_l[16:1];
	assign audio_r = mix_r[16:1];

endmodule

`default_nettype wire

// File: msu_audio_props.sv
/*
 * Concurrent checks on the host request handshake and the FIFO write side.
 * Bound into msu_audio_top, watches the fetcher outputs and the FIFO fill.
 */

`timescale 1ns/100ps
`default_nettype none

module msu_audio_props #(
	parameter int DEPTH_BITS = 12,
	parameter int REFILL_LIMIT = 1792
) (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_ack,
	input logic wr_en,
	input logic full,
	input logic [DEPTH_BITS:0] used
);
	localparam logic [DEPTH_BITS:0] REFILL_USED = (DEPTH_BITS + 1)'(REFILL_LIMIT);

	// Failed assertions so far, read at the end of the run
	int fail_count = 0;

	// Back-pressure, request decided on a fill below the limit
	refill_backpressure: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_rd) |-> ($past(used) < REFILL_USED))
	else begin
		fail_count++;
		$error("sd_rd rose while the FIFO was at or above the refill limit");
	end

	// Request level drops right after the host acknowledges
	request_drop: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd && sd_ack) |=> !sd_rd)
	else begin
		fail_count++;
		$error("sd_rd still high one cycle after sd_ack");
	end

	// No write into a full FIFO
	no_write_full: assert property (@(posedge clk_sys) disable iff (reset)
		!(wr_en && full))
	else begin
		fail_count++;
		$error("FIFO write enable high while the FIFO is full");
	end

endmodule

bind msu_audio_top msu_audio_props #(
	.DEPTH_BITS(DEPTH_BITS),
	.REFILL_LIMIT(REFILL_LIMIT)
) u_props (
	.clk_sys(clk_sys),
	.reset(reset),
	.sd_rd(sd_rd),
	.sd_ack(sd_ack),
	.wr_en(wr_if.wr_en),
	.full(wr_if.full),
	.used(wr_if.used)
);

`default_nettype wire

// File: msu_audio_top.sv
/*
 * Top level of the streamed-audio player.
 * Connects the sector fetcher, the sample FIFO and the output stage.
 * Host block interface and audio appear as plain ports.
 */

`timescale 1ns/100ps
`default_nettype none

module msu_audio_top #(
	parameter int DEPTH_BITS = 12,
	parameter int REFILL_LIMIT = 1792,
	parameter int SAMPLE_PERIOD = 566,
	parameter msu_pkg::lba_t END_FRAME = 21'h1FFFFF
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic play_trig,
	input  logic track_mounting,
	input  logic repeat_en,
	input  msu_pkg::volume_t volume,
	input  msu_pkg::sample_t main_l,
	input  msu_pkg::sample_t main_r,
	input  logic sd_ack,
	input  logic sd_buff_wr,
	input  msu_pkg::word_t sd_buff_dout,
	output logic sd_rd,
	output msu_pkg::lba_t sd_lba,
	output msu_pkg::sample_t audio_l,
	output msu_pkg::sample_t audio_r
);
	import msu_pkg::*;

	logic playing;
	// FIFO read side
	logic rd_en;
	word_t rd_data;
	logic empty;

	fifo_write_if #(.DEPTH_BITS(DEPTH_BITS)) wr_if ();

	msu_sector_fetch #(
		.REFILL_LIMIT(REFILL_LIMIT),
		.END_FRAME(END_FRAME),
		.DEPTH_BITS(DEPTH_BITS)
	) u_sector_fetch (
		.clk_sys(clk_sys),
		.reset(reset),
		.play_trig(play_trig),
		.track_mounting(track_mounting),
		.repeat_en(repeat_en),
		.sd_ack(sd_ack),
		.sd_buff_wr(sd_buff_wr),
		.sd_buff_dout(sd_buff_dout),
		.sd_rd(sd_rd),
		.sd_lba(sd_lba),
		.playing(playing),
		.wr(wr_if.fetch_mp)
	);

	// Play trigger also flushes stale words
	sample_fifo #(
		.DEPTH_BITS(DEPTH_BITS)
	) u_sample_fifo (
		.clk_sys(clk_sys),
		.reset(reset),
		.flush(play_trig),
		.wr(wr_if.fifo_mp),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.empty(empty)
	);

	msu_audio_out #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD)
	) u_audio_out (
		.clk_sys(clk_sys),
		.reset(reset),
		.play_trig(play_trig),
		.playing(playing),
		.volume(volume),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.empty(empty),
		.main_l(main_l),
		.main_r(main_r),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

endmodule

`default_nettype wire

// File: msu_pkg.sv
/*
 * Shared types and sector constants for the streamed-audio player.
 * Every design file pulls what it needs from here. Sector data arrives
 * as 16-bit words, and a PCM track is a run of 512-byte sectors.
 */

`default_nettype none

package msu_pkg;

	// ====================
	// Data types
	// ====================

	// One sector word as delivered by the host
	typedef logic [15:0] word_t;

	// Signed PCM sample, one channel
	typedef logic signed [15:0] sample_t;

	// Sector number within the track
	typedef logic [20:0] lba_t;

	// Volume, 256 would be unity gain
	typedef logic [7:0] volume_t;

	// Loop point, counted in stereo samples
	typedef logic [31:0] loop_index_t;

	// ====================
	// Sector layout
	// ====================

	// 512 bytes per sector
	localparam int SECTOR_WORDS = 256;

	// Magic word pair plus loop index at the start of sector 0
	localparam int HEADER_WORDS = 4;

	// 4 bytes per stereo sample, 512 bytes per sector
	localparam int LOOP_SHIFT = 7;

endpackage

`default_nettype wire

// File: msu_sector_fetch.sv
/*
 * Sector fetcher for the PCM track.
 * Requests 512-byte sectors from the host block interface, drops the
 * sector 0 header, keeps the loop index and pushes sample words into
 * the FIFO. Refill pauses while the FIFO holds REFILL_LIMIT words or more.
 */

`timescale 1ns/100ps
`default_nettype none

module msu_sector_fetch #(
	parameter int REFILL_LIMIT = 1792,
	parameter msu_pkg::lba_t END_FRAME = 21'h1FFFFF,
	parameter int DEPTH_BITS = 12
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic play_trig,
	input  logic track_mounting,
	input  logic repeat_en,
	input  logic sd_ack,
	input  logic sd_buff_wr,
	input  msu_pkg::word_t sd_buff_dout,
	output logic sd_rd,
	output msu_pkg::lba_t sd_lba,
	output logic playing,
	fifo_write_if.fetch_mp wr
);
	import msu_pkg::*;

	localparam int CNT_BITS = $clog2(SECTOR_WORDS);
	localparam logic [DEPTH_BITS:0] REFILL_USED = (DEPTH_BITS + 1)'(REFILL_LIMIT);
	// Header word positions of the loop index with the low half first
	localparam logic [CNT_BITS-1:0] LOOP_LO_WORD = CNT_BITS'(2);
	localparam logic [CNT_BITS-1:0] LOOP_HI_WORD = CNT_BITS'(3);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT_ACK,
		S_XFER
	} state_t;

	state_t state;
	lba_t cur_frame;
	logic [CNT_BITS-1:0] word_cnt;
	loop_index_t loop_index;
	logic xfer_word;
	logic header_skip;
	logic room;

	// Word strobe belongs to us only while a request is open
	assign xfer_word = sd_ack && sd_buff_wr && (state != S_IDLE);
	// Magic and loop index words never reach the FIFO
	assign header_skip = (sd_lba == '0) && (word_cnt < CNT_BITS'(HEADER_WORDS));
	// Back-pressure from the FIFO fill level
	assign room = wr.used < REFILL_USED;

	// Refill limit leaves room for a whole sector so the FIFO never fills
	assign wr.wr_en = xfer_word && !header_skip;
	assign wr.wr_data = sd_buff_dout;

	// ====================
	// Request FSM
	// ====================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
			playing <= 1'b0;
			sd_rd <= 1'b0;
			sd_lba <= '0;
			cur_frame <= '0;
			word_cnt <= '0;
		end else if (play_trig) begin
			// Restart the track from sector 0
			state <= S_IDLE;
			playing <= 1'b1;
			sd_rd <= 1'b0;
			cur_frame <= '0;
			word_cnt <= '0;
		end else begin
			if (xfer_word)
				word_cnt <= word_cnt + 1'b1;

			case (state)
				S_IDLE: begin
					// Hold off while the host is still mounting the track
					if (playing && !track_mounting && room) begin
						sd_lba <= cur_frame;
						sd_rd <= 1'b1;
						word_cnt <= '0;
						state <= S_WAIT_ACK;
					end
				end
				S_WAIT_ACK: begin
					// Host took the request so the level drops
					if (sd_ack) begin
						sd_rd <= 1'b0;
						state <= S_XFER;
					end
				end
				S_XFER: begin
					// Ack low ends the sector and the next one waits for FIFO room
					if (!sd_ack && room) begin
						if (cur_frame < END_FRAME) begin
							cur_frame <= cur_frame + 1'b1;
							sd_lba <= cur_frame + 1'b1;
							sd_rd <= 1'b1;
							word_cnt <= '0;
							state <= S_WAIT_ACK;
						end else if (repeat_en) begin
							// Loop restarts at the sector holding the loop sample
							cur_frame <= lba_t'(loop_index >> LOOP_SHIFT);
							state <= S_IDLE;
						end else begin
							playing <= 1'b0;
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Loop index capture from sector 0 in little-endian word order
	always_ff @(posedge clk_sys) begin
		if (xfer_word && (sd_lba == '0)) begin
			if (word_cnt == LOOP_LO_WORD)
				loop_index[15:0] <= sd_buff_dout;
			if (word_cnt == LOOP_HI_WORD)
				loop_index[31:16] <= sd_buff_dout;
		end
	end

endmodule

`default_nettype wire

// File: sample_fifo.sv
/*
 * Synchronous FIFO of 16-bit sample words.
 * Writes come in through the write interface, reads are first-word
 * fall-through. A flush empties the store in one cycle.
 */

`timescale 1ns/100ps
`default_nettype none

module sample_fifo #(
	parameter int DEPTH_BITS = 12
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic flush,
	fifo_write_if.fifo_mp wr,
	input  logic rd_en,
	output msu_pkg::word_t rd_data,
	output logic empty
);
	import msu_pkg::*;

	localparam logic [DEPTH_BITS:0] DEPTH = {1'b1, {DEPTH_BITS{1'b0}}};

	word_t mem [0:(1 << DEPTH_BITS) - 1];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0] count;
	logic do_wr;
	logic do_rd;

	assign wr.full = (count == DEPTH);
	assign wr.used = count;
	assign empty = (count == '0);

	// Head word is always visible on the read port
	assign rd_data = mem[rd_ptr];

	assign do_wr = wr.wr_en && !wr.full;
	assign do_rd = rd_en && !empty;

	// Storage
	always_ff @(posedge clk_sys) begin
		if (do_wr)
			mem[wr_ptr] <= wr.wr_data;
	end

	// Pointers and fill count, flush wins over any transfer
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tb_msu_audio.sv
/*
 * Testbench for the streamed-audio player.
 * Models the host block interface, plays a short three-sector track and
 * checks request order, header skip, mixing, repeat and stop behavior.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_msu_audio;
	import msu_pkg::*;

	localparam int DEPTH_BITS = 9;
	localparam int REFILL_LIMIT = 256;
	localparam int SAMPLE_PERIOD = 6;
	localparam lba_t END_FRAME = 21'd2;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = 200 * (SAMPLE_PERIOD + 1) * NUM_TESTS;
	// Track content and mix levels
	localparam int MAIN_LEVEL = 400;
	localparam int VOLUME_LEVEL = 128;
	localparam int LEFT_VALUE = 1000;
	localparam int RIGHT_VALUE = -2000;
	localparam int LOOP_POINT = 256;

	logic clk_sys;
	logic reset;
	logic play_trig;
	logic track_mounting;
	logic repeat_en;
	volume_t volume;
	sample_t main_l;
	sample_t main_r;
	logic sd_ack;
	logic sd_buff_wr;
	word_t sd_buff_dout;
	logic sd_rd;
	lba_t sd_lba;
	sample_t audio_l;
	sample_t audio_r;

	integer seed = 23;
	int check_errors = 0;
	// Sector number of every request, in order
	lba_t req_lba [$];
	logic sd_rd_q = 1'b0;

	msu_audio_top #(
		.DEPTH_BITS(DEPTH_BITS),
		.REFILL_LIMIT(REFILL_LIMIT),
		.SAMPLE_PERIOD(SAMPLE_PERIOD),
		.END_FRAME(END_FRAME)
	) u_msu_audio_top (
		.clk_sys(clk_sys),
		.reset(reset),
		.play_trig(play_trig),
		.track_mounting(track_mounting),
		.repeat_en(repeat_en),
		.volume(volume),
		.main_l(main_l),
		.main_r(main_r),
		.sd_ack(sd_ack),
		.sd_buff_wr(sd_buff_wr),
		.sd_buff_dout(sd_buff_dout),
		.sd_rd(sd_rd),
		.sd_lba(sd_lba),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

	// 20 ns clock
	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	// ====================
	// Reference model
	// ====================
	// Volume scale to 1/256 steps, then average with main audio
	function automatic int expected_mix(input int main_level, input int sample, input int vol);
		int share;
		share = (sample * vol) >>> 8;
		return (main_level + share) >>> 1;
	endfunction

	// Sector 0 opens with magic pair and loop index, then left/right pairs
	function automatic word_t sector_word(input lba_t lba, input int idx);
		word_t w;
		if (lba == '0 && idx < HEADER_WORDS) begin
			case (idx)
				0: w = 16'h4D53;
				1: w = 16'h5531;
				2: w = LOOP_POINT[15:0];
				default: w = LOOP_POINT[31:16];
			endcase
		end else if (idx % 2 == 0) begin
			w = 16'(LEFT_VALUE);
		end else begin
			w = 16'(RIGHT_VALUE);
		end
		return w;
	endfunction

	task automatic check_value(input string name, input int expected,
			input logic signed [31:0] actual);
		assert (actual === expected) else begin
			check_errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic pulse_play_trig(input logic mounting);
		@(posedge clk_sys);
		#1;
		play_trig = 1'b1;
		track_mounting = mounting;
		@(posedge clk_sys);
		#1;
		play_trig = 1'b0;
	endtask

	// ====================
	// Host block interface
	// ====================
	// Ack after a random delay, one word per cycle, ack low ends the sector
	task automatic serve_sector(input lba_t lba);
		int delay;
		delay = ($random(seed) & 7) + 1;
		repeat (delay) @(posedge clk_sys);
		#1;
		sd_ack = 1'b1;
		for (int i = 0; i < SECTOR_WORDS; i++) begin
			@(posedge clk_sys);
			#1;
			sd_buff_wr = 1'b1;
			sd_buff_dout = sector_word(lba, i);
		end
		@(posedge clk_sys);
		#1;
		sd_ack = 1'b0;
		sd_buff_wr = 1'b0;
	endtask

	initial begin : host_model
		forever begin
			@(negedge clk_sys);
			if (sd_rd === 1'b1)
				serve_sector(sd_lba);
		end
	end

	// Request log, sampled mid-cycle
	always @(negedge clk_sys) begin
		if (sd_rd === 1'b1 && sd_rd_q !== 1'b1)
			req_lba.push_back(sd_lba);
		sd_rd_q <= sd_rd;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout, run still busy after %0d clock cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ====================
	// Stimulus
	// ====================
	initial begin
		int idle_level;
		int exp_lba [4];
		idle_level = expected_mix(MAIN_LEVEL, 0, VOLUME_LEVEL);
		exp_lba = '{0, 1, 2, LOOP_POINT >> LOOP_SHIFT};
		play_trig = 1'b0;
		track_mounting = 1'b0;
		repeat_en = 1'b1;
		volume = 8'(VOLUME_LEVEL);
		main_l = 16'(MAIN_LEVEL);
		main_r = 16'(MAIN_LEVEL);
		sd_ack = 1'b0;
		sd_buff_wr = 1'b0;
		sd_buff_dout = '0;
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Idle after reset, only main audio at half level
		@(negedge clk_sys);
		check_value("reset sd_rd", 0, 32'(sd_rd));
		check_value("reset audio_l", idle_level, 32'(audio_l));
		check_value("reset audio_r", idle_level, 32'(audio_r));

		// Track still mounting, restart must wait
		pulse_play_trig(1'b1);
		repeat (20) begin
			@(negedge clk_sys);
			check_value("mounting sd_rd", 0, 32'(sd_rd));
		end

		// Mounted, request for sector 0 on the second edge
		pulse_play_trig(1'b0);
		@(negedge clk_sys);
		check_value("first edge sd_rd", 0, 32'(sd_rd));
		@(negedge clk_sys);
		check_value("second edge sd_rd", 1, 32'(sd_rd));
		check_value("second edge sd_lba", 0, 32'(sd_lba));

		// First played pair comes after the header words
		do
			@(negedge clk_sys);
		while ($isunknown(audio_l) || 32'(audio_l) == idle_level);
		check_value("first pair audio_l",
			expected_mix(MAIN_LEVEL, LEFT_VALUE, VOLUME_LEVEL), 32'(audio_l));
		check_value("first pair audio_r",
			expected_mix(MAIN_LEVEL, RIGHT_VALUE, VOLUME_LEVEL), 32'(audio_r));

		// Sectors 0..2, then the loop sector
		while (req_lba.size() < 4)
			@(negedge clk_sys);
		for (int i = 0; i < 4; i++)
			check_value($sformatf("request %0d sd_lba", i), exp_lba[i], 32'(req_lba[i]));

		// Repeat off, the looped sector is the last one
		@(posedge clk_sys);
		#1;
		repeat_en = 1'b0;
		do
			@(negedge clk_sys);
		while ($isunknown(audio_l) || 32'(audio_l) != idle_level);
		check_value("stopped audio_r", idle_level, 32'(audio_r));
		repeat (50 * (SAMPLE_PERIOD + 1)) @(negedge clk_sys);
		check_value("stopped request count", 4, req_lba.size());
		check_value("stopped sd_rd", 0, 32'(sd_rd));
		check_value("stopped audio_l", idle_level, 32'(audio_l));

		$display("Errors: %0d procedural, %0d assertion", check_errors,
			u_msu_audio_top.u_props.fail_count);
		if (check_errors == 0 && u_msu_audio_top.u_props.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
msu_pkg.sv
fifo_write_if.sv
msu_sector_fetch.sv
sample_fifo.sv
msu_audio_out.sv
msu_audio_top.sv
msu_audio_props.sv
tb_msu_audio.sv
